// File: verilog/rv_exec_pkg.sv
// RV32IM execute stage definitions

package rv_exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and multiplier length
    ////////////////////////////////////////////////////////////////////////////

    // Data and address width
    localparam int XLEN = 32;

    // One partial product per iteration cycle
    localparam int MUL_CYCLES = 32;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);
    // Counter value on the final iteration
    localparam logic [MUL_CNT_W-1:0] MUL_LAST = MUL_CNT_W'(MUL_CYCLES - 1);

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and selects
    ////////////////////////////////////////////////////////////////////////////

    // ALU operation, 11 of 16 codes used
    typedef enum logic [3:0] {
        ADD = 4'd0, SUB = 4'd1, SLL = 4'd2, SLT = 4'd3, SLTU = 4'd4, XOR = 4'd5,
        SRL = 4'd6, SRA = 4'd7, OR = 4'd8, AND = 4'd9, PASS_B = 4'd10
    } alu_op_e;

    // Operand A source
    typedef enum logic {SRC_A_REG = 1'b0, SRC_A_PC = 1'b1} src_a_e;

    // Operand B source
    typedef enum logic {SRC_B_REG = 1'b0, SRC_B_IMM = 1'b1} src_b_e;

    // Forwarding choice, 2'b11 is illegal
    typedef enum logic [1:0] {FWD_REG = 2'd0, FWD_MEM = 2'd1, FWD_WB = 2'd2} fwd_sel_e;

    // Stage result source
    typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MUL = 2'd1, WB_PC4 = 2'd2} wb_sel_e;

    // Branch condition, same codes as funct3
    typedef enum logic [2:0] {
        BEQ = 3'b000, BNE = 3'b001, BLT = 3'b100, BGE = 3'b101, BLTU = 3'b110, BGEU = 3'b111
    } br_cond_e;

    // Multiply variant, low two bits of funct3
    typedef enum logic [1:0] {MUL = 2'd0, MULH = 2'd1, MULHSU = 2'd2, MULHU = 2'd3} mul_op_e;

    // Multiplier FSM state
    typedef enum logic [1:0] {IDLE = 2'd0, BUSY = 2'd1, DONE = 2'd2} mult_state_e;

endpackage

// File: verilog/operand_select.sv
// Operand forwarding and source select

`timescale 1ns/1ns

module operand_select (
    input  rv_exec_pkg::fwd_sel_e           fwd_a_sel_i,
    input  rv_exec_pkg::fwd_sel_e           fwd_b_sel_i,
    input  rv_exec_pkg::src_a_e             src_a_i,
    input  rv_exec_pkg::src_b_e             src_b_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    rs1_data_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    rs2_data_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    mem_fwd_data_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    wb_fwd_data_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    pc_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    imm_i,
    output logic [rv_exec_pkg::XLEN-1:0]    fwd_a_o,
    output logic [rv_exec_pkg::XLEN-1:0]    fwd_b_o,
    output logic [rv_exec_pkg::XLEN-1:0]    alu_a_o,
    output logic [rv_exec_pkg::XLEN-1:0]    alu_b_o
);

    // rs1 value, newest copy wins as chosen by the hazard unit
    always_comb begin
        case (fwd_a_sel_i)
            rv_exec_pkg::FWD_MEM: fwd_a_o = mem_fwd_data_i;
            rv_exec_pkg::FWD_WB:  fwd_a_o = wb_fwd_data_i;
            default:              fwd_a_o = rs1_data_i;
        endcase
    end

    // rs2 value, also the store data
    always_comb begin
        case (fwd_b_sel_i)
            rv_exec_pkg::FWD_MEM: fwd_b_o = mem_fwd_data_i;
            rv_exec_pkg::FWD_WB:  fwd_b_o = wb_fwd_data_i;
            default:              fwd_b_o = rs2_data_i;
        endcase
    end

    // AUIPC and JAL take the PC, I-type and stores take the immediate
    assign alu_a_o = (src_a_i == rv_exec_pkg::SRC_A_PC) ? pc_i : fwd_a_o;
    assign alu_b_o = (src_b_i == rv_exec_pkg::SRC_B_IMM) ? imm_i : fwd_b_o;

    // Hazard unit never emits the unused forward code
    always_comb begin
        assert (fwd_a_sel_i != 2'b11 && fwd_b_sel_i != 2'b11)
            else $error("illegal forward select");
    end

endmodule

// File: verilog/exec_alu.sv
// Integer ALU

`timescale 1ns/1ns

module exec_alu (
    input  rv_exec_pkg::alu_op_e            alu_op_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    operand_a_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    operand_b_i,
    output logic [rv_exec_pkg::XLEN-1:0]    result_o,
    output logic                            zero_o,
    output logic                            overflow_o
);

    // Shift amount is the low five bits of B
    logic [4:0]                     shamt;
    logic [rv_exec_pkg::XLEN-1:0]   sum;
    logic [rv_exec_pkg::XLEN-1:0]   diff;

    assign shamt = operand_b_i[4:0];
    assign sum   = operand_a_i + operand_b_i;
    assign diff  = operand_a_i - operand_b_i;

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_op_i)
            rv_exec_pkg::ADD:    result_o = sum;
            rv_exec_pkg::SUB:    result_o = diff;
            rv_exec_pkg::SLL:    result_o = operand_a_i << shamt;
            // Set-less-than gives 0 or 1 in bit 0
            rv_exec_pkg::SLT:    result_o = {31'd0, $signed(operand_a_i) < $signed(operand_b_i)};
            rv_exec_pkg::SLTU:   result_o = {31'd0, operand_a_i < operand_b_i};
            rv_exec_pkg::XOR:    result_o = operand_a_i ^ operand_b_i;
            rv_exec_pkg::SRL:    result_o = operand_a_i >> shamt;
            // Arithmetic shift keeps the sign
            rv_exec_pkg::SRA:    result_o = $unsigned($signed(operand_a_i) >>> shamt);
            rv_exec_pkg::OR:     result_o = operand_a_i | operand_b_i;
            rv_exec_pkg::AND:    result_o = operand_a_i & operand_b_i;
            // LUI path, immediate straight through
            rv_exec_pkg::PASS_B: result_o = operand_b_i;
            default:             result_o = '0;
        endcase
    end

    // Branch compare uses SUB and checks for zero
    assign zero_o = (result_o == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Signed overflow flag
    ////////////////////////////////////////////////////////////////////////////

    // ADD overflows when both signs agree and the sum sign differs
    // SUB overflows when signs differ and the result sign leaves A
    always_comb begin
        case (alu_op_i)
            rv_exec_pkg::ADD: overflow_o = (operand_a_i[31] == operand_b_i[31]) &&
                                           (sum[31] != operand_a_i[31]);
            rv_exec_pkg::SUB: overflow_o = (operand_a_i[31] != operand_b_i[31]) &&
                                           (diff[31] != operand_a_i[31]);
            default:          overflow_o = 1'b0;
        endcase
    end

endmodule

// File: verilog/mult_unit.sv
// Iterative shift-add multiplier

`timescale 1ns/1ns

module mult_unit (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            start_i,
    input  rv_exec_pkg::mul_op_e            mul_op_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    operand_a_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    operand_b_i,
    input  logic                            hold_i,
    output logic [rv_exec_pkg::XLEN-1:0]    result_o,
    output logic                            stall_req_o
);

    rv_exec_pkg::mult_state_e           state_q;
    logic [rv_exec_pkg::MUL_CNT_W-1:0]  cnt_q;
    // Magnitude multiply, sign applied at the end
    logic [rv_exec_pkg::XLEN-1:0]       mcand_q;
    logic [rv_exec_pkg::XLEN-1:0]       hi_q;
    logic [rv_exec_pkg::XLEN-1:0]       lo_q;
    logic                               neg_q;
    rv_exec_pkg::mul_op_e               op_q;
    logic                               a_neg;
    logic                               b_neg;
    logic [rv_exec_pkg::XLEN:0]         step_sum;
    logic [2*rv_exec_pkg::XLEN-1:0]     product;

    // Operand A is signed for MULH and MULHSU, B only for MULH
    assign a_neg = operand_a_i[31] && (mul_op_i == rv_exec_pkg::MULH ||
                                       mul_op_i == rv_exec_pkg::MULHSU);
    assign b_neg = operand_b_i[31] && (mul_op_i == rv_exec_pkg::MULH);

    // Add multiplicand to the upper half when the multiplier bit is set
    assign step_sum = {1'b0, hi_q} + (lo_q[0] ? {1'b0, mcand_q} : '0);

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= rv_exec_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                rv_exec_pkg::IDLE: if (start_i) begin
                    state_q <= rv_exec_pkg::BUSY;
                    cnt_q   <= '0;
                end
                rv_exec_pkg::BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == rv_exec_pkg::MUL_LAST) state_q <= rv_exec_pkg::DONE;
                end
                // Product stays up until EX/MEM takes it
                rv_exec_pkg::DONE: if (!hold_i) state_q <= rv_exec_pkg::IDLE;
                default: state_q <= rv_exec_pkg::IDLE;
            endcase
        end
    end

    // Datapath, one bit of the multiplier retired per BUSY cycle
    always_ff @(posedge clk_i) begin
        if (state_q == rv_exec_pkg::IDLE && start_i) begin
            mcand_q <= a_neg ? -operand_a_i : operand_a_i;
            lo_q    <= b_neg ? -operand_b_i : operand_b_i;
            hi_q    <= '0;
            neg_q   <= a_neg ^ b_neg;
            op_q    <= mul_op_i;
        end else if (state_q == rv_exec_pkg::BUSY) begin
            hi_q <= step_sum[rv_exec_pkg::XLEN:1];
            lo_q <= {step_sum[0], lo_q[rv_exec_pkg::XLEN-1:1]};
        end
    end

    // Restore sign, MUL takes the low word and the rest the high word
    assign product  = neg_q ? -{hi_q, lo_q} : {hi_q, lo_q};
    assign result_o = (op_q == rv_exec_pkg::MUL) ? product[31:0] : product[63:32];

    // Stall from first presentation until the product is ready
    assign stall_req_o = start_i && (state_q != rv_exec_pkg::DONE);

    // ID/EX is frozen for the whole iteration
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q == rv_exec_pkg::BUSY |-> $stable(operand_a_i) && $stable(operand_b_i));

endmodule

// File: verilog/branch_resolve.sv
// Branch and jump resolution

`timescale 1ns/1ns

module branch_resolve (
    input  logic                            is_branch_i,
    input  logic                            is_jump_i,
    input  logic                            is_jalr_i,
    input  logic [2:0]                      funct3_i,
    input  logic                            zero_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    alu_result_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    pc_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    imm_i,
    output logic                            redirect_o,
    output logic [rv_exec_pkg::XLEN-1:0]    redirect_target_o
);

    logic taken;

    ////////////////////////////////////////////////////////////////////////////
    // Condition evaluation
    ////////////////////////////////////////////////////////////////////////////

    // Equality from SUB, ordering from bit 0 of SLT or SLTU
    always_comb begin
        case (rv_exec_pkg::br_cond_e'(funct3_i))
            rv_exec_pkg::BEQ:  taken = zero_i;
            rv_exec_pkg::BNE:  taken = !zero_i;
            rv_exec_pkg::BLT,
            rv_exec_pkg::BLTU: taken = alu_result_i[0];
            rv_exec_pkg::BGE,
            rv_exec_pkg::BGEU: taken = !alu_result_i[0];
            default:           taken = 1'b0;
        endcase
    end

    // Jumps always redirect
    assign redirect_o = (is_branch_i && taken) || is_jump_i || is_jalr_i;

    // JALR target is rs1 plus imm from the ALU, LSB forced low
    assign redirect_target_o = is_jalr_i ? {alu_result_i[rv_exec_pkg::XLEN-1:1], 1'b0}
                                         : pc_i + imm_i;

endmodule

// File: verilog/ex_mem_register.sv
// EX/MEM pipeline register

`timescale 1ns/1ns

module ex_mem_register (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            stall_m_i,
    input  logic                            flush_e_i,
    input  logic                            exec_stall_i,
    input  rv_exec_pkg::wb_sel_e            wb_sel_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    alu_result_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    mul_result_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    pc_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    store_data_i,
    input  logic [4:0]                      rd_addr_i,
    input  logic                            overflow_i,
    input  logic                            reg_write_i,
    input  logic                            mem_read_i,
    input  logic                            mem_write_i,
    output logic [rv_exec_pkg::XLEN-1:0]    result_o,
    output logic [rv_exec_pkg::XLEN-1:0]    store_data_o,
    output logic [4:0]                      rd_addr_o,
    output logic                            overflow_o,
    output logic                            reg_write_o,
    output logic                            mem_read_o,
    output logic                            mem_write_o
);

    logic [rv_exec_pkg::XLEN-1:0] result_sel;

    // Link address for JAL and JALR
    always_comb begin
        case (wb_sel_i)
            rv_exec_pkg::WB_MUL: result_sel = mul_result_i;
            rv_exec_pkg::WB_PC4: result_sel = pc_i + 32'd4;
            default:             result_sel = alu_result_i;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control bits: hold, then flush, then multiply bubble, then load
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            reg_write_o <= 1'b0;
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
        end else if (!stall_m_i) begin
            reg_write_o <= reg_write_i && !flush_e_i && !exec_stall_i;
            mem_read_o  <= mem_read_i && !flush_e_i && !exec_stall_i;
            mem_write_o <= mem_write_i && !flush_e_i && !exec_stall_i;
        end
    end

    // Payload follows unless memory stage holds, bubbles ignore it
    always_ff @(posedge clk_i) begin
        if (!stall_m_i) begin
            result_o     <= result_sel;
            store_data_o <= store_data_i;
            rd_addr_o    <= rd_addr_i;
            overflow_o   <= overflow_i;
        end
    end

    // Decode never marks a load and a store together
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(mem_read_o && mem_write_o));

endmodule

// File: verilog/execute_stage.sv
// RV32IM execute stage top

`timescale 1ns/1ns

module execute_stage (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // ID/EX fields
    input  logic [rv_exec_pkg::XLEN-1:0]    pc_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    rs1_data_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    rs2_data_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    imm_i,
    input  logic [4:0]                      rd_addr_i,
    input  rv_exec_pkg::alu_op_e            alu_op_i,
    input  rv_exec_pkg::src_a_e             src_a_i,
    input  rv_exec_pkg::src_b_e             src_b_i,
    input  rv_exec_pkg::wb_sel_e            wb_sel_i,
    input  logic [2:0]                      funct3_i,
    input  logic                            is_branch_i,
    input  logic                            is_jump_i,
    input  logic                            is_jalr_i,
    input  logic                            reg_write_i,
    input  logic                            mem_read_i,
    input  logic                            mem_write_i,
    // Hazard unit decisions and forwarded data
    input  rv_exec_pkg::fwd_sel_e           fwd_a_sel_i,
    input  rv_exec_pkg::fwd_sel_e           fwd_b_sel_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    mem_fwd_data_i,
    input  logic [rv_exec_pkg::XLEN-1:0]    wb_fwd_data_i,
    input  logic                            stall_m_i,
    input  logic                            flush_e_i,
    // To fetch and hazard unit
    output logic                            redirect_o,
    output logic [rv_exec_pkg::XLEN-1:0]    redirect_target_o,
    output logic                            exec_stall_req_o,
    // EX/MEM register
    output logic [rv_exec_pkg::XLEN-1:0]    result_o,
    output logic [rv_exec_pkg::XLEN-1:0]    store_data_o,
    output logic [4:0]                      rd_addr_o,
    output logic                            reg_write_o,
    output logic                            mem_read_o,
    output logic                            mem_write_o,
    output logic                            overflow_o
);

    logic [rv_exec_pkg::XLEN-1:0] fwd_a;
    logic [rv_exec_pkg::XLEN-1:0] fwd_b;
    logic [rv_exec_pkg::XLEN-1:0] alu_a;
    logic [rv_exec_pkg::XLEN-1:0] alu_b;
    logic [rv_exec_pkg::XLEN-1:0] alu_result;
    logic [rv_exec_pkg::XLEN-1:0] mul_result;
    logic                         zero;
    logic                         overflow;

    operand_select operand_select_inst (
        .fwd_a_sel_i, .fwd_b_sel_i, .src_a_i, .src_b_i, .rs1_data_i, .rs2_data_i,
        .mem_fwd_data_i, .wb_fwd_data_i, .pc_i, .imm_i,
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .alu_a_o(alu_a), .alu_b_o(alu_b)
    );

    exec_alu exec_alu_inst (
        .alu_op_i, .operand_a_i(alu_a), .operand_b_i(alu_b),
        .result_o(alu_result), .zero_o(zero), .overflow_o(overflow)
    );

    // Multiply selected by the writeback source, variant by funct3
    mult_unit mult_unit_inst (
        .clk_i, .rst_ni, .start_i(wb_sel_i == rv_exec_pkg::WB_MUL),
        .mul_op_i(rv_exec_pkg::mul_op_e'(funct3_i[1:0])),
        .operand_a_i(fwd_a), .operand_b_i(fwd_b), .hold_i(stall_m_i),
        .result_o(mul_result), .stall_req_o(exec_stall_req_o)
    );

    branch_resolve branch_resolve_inst (
        .is_branch_i, .is_jump_i, .is_jalr_i, .funct3_i, .zero_i(zero),
        .alu_result_i(alu_result), .pc_i, .imm_i, .redirect_o, .redirect_target_o
    );

    ex_mem_register ex_mem_register_inst (
        .clk_i, .rst_ni, .stall_m_i, .flush_e_i, .exec_stall_i(exec_stall_req_o),
        .wb_sel_i, .alu_result_i(alu_result), .mul_result_i(mul_result), .pc_i,
        .store_data_i(fwd_b), .rd_addr_i, .overflow_i(overflow), .reg_write_i,
        .mem_read_i, .mem_write_i, .result_o, .store_data_o, .rd_addr_o, .overflow_o,
        .reg_write_o, .mem_read_o, .mem_write_o
    );

endmodule

// File: verif/execute_stage_tb.sv
// Execute stage testbench

`timescale 1ns/1ns

module execute_stage_tb;

    localparam int CLK_PERIOD = 100;
    // Reset, ALU, forwarding, branches, multiplies, hold and flush, plus margin
    localparam int TOTAL_INSTR = 1 + 200 + 9 + 14 + 16 + 6 + 10;

    logic clk_i = 1'b0;
    logic rst_ni = 1'b0;
    logic [31:0] pc_i, rs1_data_i, rs2_data_i, imm_i, mem_fwd_data_i, wb_fwd_data_i;
    logic [4:0] rd_addr_i;
    rv_exec_pkg::alu_op_e alu_op_i;
    rv_exec_pkg::src_a_e src_a_i;
    rv_exec_pkg::src_b_e src_b_i;
    rv_exec_pkg::wb_sel_e wb_sel_i;
    rv_exec_pkg::fwd_sel_e fwd_a_sel_i, fwd_b_sel_i;
    logic [2:0] funct3_i;
    logic is_branch_i, is_jump_i, is_jalr_i, reg_write_i, mem_read_i, mem_write_i;
    logic stall_m_i, flush_e_i;
    logic redirect_o, exec_stall_req_o, reg_write_o, mem_read_o, mem_write_o, overflow_o;
    logic [31:0] redirect_target_o, result_o, store_data_o;
    logic [4:0] rd_addr_o;

    int errors = 0;
    int checks = 0;
    logic [31:0] seed = 32'h980e;
    string test_name = "reset";
    event load_ev;

    execute_stage execute_stage_inst (.*);

    // Free running clock
    initial begin
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] pick_source(rv_exec_pkg::fwd_sel_e sel, logic [31:0] rf);
        if (sel == rv_exec_pkg::FWD_MEM) return mem_fwd_data_i;
        if (sel == rv_exec_pkg::FWD_WB) return wb_fwd_data_i;
        return rf;
    endfunction

    // Expected stage behavior from the presented fields
    function automatic void ref_model(output logic [31:0] res, output logic ovf,
                                      output logic redir, output logic [31:0] tgt);
        logic [31:0] fa, fb, opa, opb, alu;
        logic signed [32:0] wide;
        logic [63:0] prod;
        logic taken;
        fa = pick_source(fwd_a_sel_i, rs1_data_i);
        fb = pick_source(fwd_b_sel_i, rs2_data_i);
        opa = (src_a_i == rv_exec_pkg::SRC_A_PC) ? pc_i : fa;
        opb = (src_b_i == rv_exec_pkg::SRC_B_IMM) ? imm_i : fb;
        ovf = 1'b0;
        case (alu_op_i)
            rv_exec_pkg::ADD: begin
                wide = $signed({opa[31], opa}) + $signed({opb[31], opb});
                alu = wide[31:0];
                ovf = wide[32] != wide[31];
            end
            rv_exec_pkg::SUB: begin
                wide = $signed({opa[31], opa}) - $signed({opb[31], opb});
                alu = wide[31:0];
                ovf = wide[32] != wide[31];
            end
            rv_exec_pkg::SLL:  alu = opa << opb[4:0];
            rv_exec_pkg::SLT:  alu = ($signed(opa) < $signed(opb)) ? 32'd1 : 32'd0;
            rv_exec_pkg::SLTU: alu = (opa < opb) ? 32'd1 : 32'd0;
            rv_exec_pkg::XOR:  alu = opa ^ opb;
            rv_exec_pkg::SRL:  alu = opa >> opb[4:0];
            rv_exec_pkg::SRA:  alu = 32'($signed(opa) >>> opb[4:0]);
            rv_exec_pkg::OR:   alu = opa | opb;
            rv_exec_pkg::AND:  alu = opa & opb;
            default:           alu = opb;
        endcase
        // Full 64-bit products, sign handled by extension
        case (funct3_i[1:0])
            2'd1:    prod = {{32{fa[31]}}, fa} * {{32{fb[31]}}, fb};
            2'd2:    prod = {{32{fa[31]}}, fa} * {32'd0, fb};
            default: prod = {32'd0, fa} * {32'd0, fb};
        endcase
        case (wb_sel_i)
            rv_exec_pkg::WB_MUL: res = (funct3_i[1:0] == 2'd0) ? prod[31:0] : prod[63:32];
            rv_exec_pkg::WB_PC4: res = pc_i + 32'd4;
            default:             res = alu;
        endcase
        case (funct3_i)
            3'b000:  taken = fa == fb;
            3'b001:  taken = fa != fb;
            3'b100:  taken = $signed(fa) < $signed(fb);
            3'b101:  taken = $signed(fa) >= $signed(fb);
            3'b110:  taken = fa < fb;
            3'b111:  taken = fa >= fb;
            default: taken = 1'b0;
        endcase
        redir = (is_branch_i && taken) || is_jump_i || is_jalr_i;
        tgt = is_jalr_i ? ((fa + imm_i) & ~32'd1) : pc_i + imm_i;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(string what, logic [rv_exec_pkg::XLEN-1:0] exp,
                              logic [rv_exec_pkg::XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_rd(logic [4:0] exp, logic [4:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s rd_addr expected %0d actual %0d", test_name, exp, act);
        end
    endtask

    // Compare process, runs at the sample point after each load edge
    always @(load_ev) begin
        logic [31:0] res, tgt;
        logic ovf, redir;
        ref_model(res, ovf, redir, tgt);
        check_word("result", res, result_o);
        check_bit("overflow", ovf, overflow_o);
        check_rd(rd_addr_i, rd_addr_o);
        check_bit("reg_write", reg_write_i, reg_write_o);
        check_bit("mem_read", mem_read_i, mem_read_o);
        check_bit("mem_write", mem_write_i, mem_write_o);
    end

    // Same-cycle redirect check
    task automatic check_redirect();
        logic [31:0] res, tgt;
        logic ovf, redir;
        #1;
        ref_model(res, ovf, redir, tgt);
        check_bit("redirect", redir, redirect_o);
        if (redir) check_word("target", tgt, redirect_target_o);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_defaults();
        {pc_i, rs1_data_i, rs2_data_i, imm_i} = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        mem_fwd_data_i = lcg_next();
        wb_fwd_data_i = lcg_next();
        rd_addr_i = 5'(lcg_next());
        alu_op_i = rv_exec_pkg::ADD;
        src_a_i = rv_exec_pkg::SRC_A_REG;
        src_b_i = rv_exec_pkg::SRC_B_REG;
        wb_sel_i = rv_exec_pkg::WB_ALU;
        fwd_a_sel_i = rv_exec_pkg::FWD_REG;
        fwd_b_sel_i = rv_exec_pkg::FWD_REG;
        funct3_i = 3'd0;
        {is_branch_i, is_jump_i, is_jalr_i} = 3'b000;
        {reg_write_i, mem_read_i, mem_write_i} = 3'b100;
        {stall_m_i, flush_e_i} = 2'b00;
    endtask

    // Edge, compare at +5, back to the drive point at +10
    task automatic load_and_check();
        @(posedge clk_i);
        #5;
        ->load_ev;
        #5;
    endtask

    task automatic run_mul(logic [1:0] op, logic [31:0] a, logic [31:0] b);
        int n;
        drive_defaults();
        wb_sel_i = rv_exec_pkg::WB_MUL;
        funct3_i = {1'b0, op};
        rs1_data_i = a;
        rs2_data_i = b;
        n = 0;
        #1;
        check_bit("stall_req at start", 1'b1, exec_stall_req_o);
        do begin
            @(posedge clk_i);
            #5;
            n++;
            check_bit("reg_write during stall", 1'b0, reg_write_o);
        end while (exec_stall_req_o && n < rv_exec_pkg::MUL_CYCLES + 5);
        check_word("stall edges", 32'(rv_exec_pkg::MUL_CYCLES + 1), 32'(n));
        #5;
        load_and_check();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] hold_res, hold_sd;
        logic [4:0] hold_rd;
        logic hold_ovf;
        logic [31:0] mul_a [4];
        logic [31:0] mul_b [4];
        drive_defaults();
        repeat (4) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        #1;
        check_bit("reg_write", 1'b0, reg_write_o);
        check_bit("mem_read", 1'b0, mem_read_o);
        check_bit("mem_write", 1'b0, mem_write_o);
        check_bit("stall_req", 1'b0, exec_stall_req_o);
        #4;

        test_name = "alu";
        repeat (200) begin
            drive_defaults();
            alu_op_i = rv_exec_pkg::alu_op_e'(4'(lcg_next() % 11));
            src_a_i = rv_exec_pkg::src_a_e'(lcg_next() >> 31);
            src_b_i = rv_exec_pkg::src_b_e'(lcg_next() >> 31);
            load_and_check();
        end

        test_name = "forwarding";
        for (int sa = 0; sa < 3; sa++) begin
            for (int sb = 0; sb < 3; sb++) begin
                drive_defaults();
                fwd_a_sel_i = rv_exec_pkg::fwd_sel_e'(2'(sa));
                fwd_b_sel_i = rv_exec_pkg::fwd_sel_e'(2'(sb));
                alu_op_i = (sa == sb) ? rv_exec_pkg::PASS_B : rv_exec_pkg::ADD;
                load_and_check();
                check_word("store_data", pick_source(fwd_b_sel_i, rs2_data_i), store_data_o);
            end
        end

        test_name = "branch";
        for (int c = 0; c < 8; c++) begin
            if (c == 2 || c == 3) continue;
            for (int eq = 0; eq < 2; eq++) begin
                drive_defaults();
                is_branch_i = 1'b1;
                reg_write_i = 1'b0;
                funct3_i = 3'(c);
                if (eq == 1) rs2_data_i = rs1_data_i;
                alu_op_i = (c < 2) ? rv_exec_pkg::SUB :
                           (c < 6) ? rv_exec_pkg::SLT : rv_exec_pkg::SLTU;
                check_redirect();
                #9;
                load_and_check();
            end
        end
        // JAL then JALR, both link PC plus 4
        for (int j = 0; j < 2; j++) begin
            test_name = (j == 0) ? "jal" : "jalr";
            drive_defaults();
            wb_sel_i = rv_exec_pkg::WB_PC4;
            src_a_i = (j == 0) ? rv_exec_pkg::SRC_A_PC : rv_exec_pkg::SRC_A_REG;
            src_b_i = rv_exec_pkg::SRC_B_IMM;
            is_jump_i = (j == 0);
            is_jalr_i = (j == 1);
            check_redirect();
            #9;
            load_and_check();
        end

        test_name = "multiply";
        mul_a = '{lcg_next(), 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000};
        mul_b = '{lcg_next(), 32'hffff_ffff, 32'h0000_0000, 32'h8000_0000};
        for (int op = 0; op < 4; op++) begin
            for (int k = 0; k < 4; k++) run_mul(2'(op), mul_a[k], mul_b[k]);
        end

        test_name = "hold";
        drive_defaults();
        mem_read_i = 1'b1;
        load_and_check();
        hold_res = result_o;
        hold_sd = store_data_o;
        hold_rd = rd_addr_o;
        hold_ovf = overflow_o;
        drive_defaults();
        reg_write_i = 1'b0;
        mem_write_i = 1'b1;
        stall_m_i = 1'b1;
        @(posedge clk_i);
        #5;
        check_word("result", hold_res, result_o);
        check_word("store_data", hold_sd, store_data_o);
        check_rd(hold_rd, rd_addr_o);
        check_bit("overflow", hold_ovf, overflow_o);
        check_bit("reg_write", 1'b1, reg_write_o);
        check_bit("mem_read", 1'b1, mem_read_o);
        check_bit("mem_write", 1'b0, mem_write_o);
        #5;

        test_name = "flush";
        drive_defaults();
        mem_read_i = 1'b1;
        flush_e_i = 1'b1;
        @(posedge clk_i);
        #5;
        check_bit("reg_write", 1'b0, reg_write_o);
        check_bit("mem_read", 1'b0, mem_read_o);
        check_bit("mem_write", 1'b0, mem_write_o);
        #5;
        // Store flushed once, then the same store loads
        drive_defaults();
        reg_write_i = 1'b0;
        mem_write_i = 1'b1;
        flush_e_i = 1'b1;
        @(posedge clk_i);
        #5;
        check_bit("mem_write", 1'b0, mem_write_o);
        #5;
        flush_e_i = 1'b0;
        load_and_check();
        drive_defaults();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the instruction count and the multiply length
    initial begin
        #(TOTAL_INSTR * (rv_exec_pkg::MUL_CYCLES + 3) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Regression failed");
        $finish;
    end

endmodule

// File: filelist.f
verilog/rv_exec_pkg.sv
verilog/operand_select.sv
verilog/exec_alu.sv
verilog/mult_unit.sv
verilog/branch_resolve.sv
verilog/ex_mem_register.sv
verilog/execute_stage.sv
verif/execute_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage regression with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module execute_stage_tb \
    --Mdir "$OBJ" -o execute_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Compile step failed with status $status"
    exit 1
fi

"./$OBJ/execute_stage_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Regression passed" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0
